//--- tests/rv_lsu_stim.txt
// op size unsigned base offset wdata rd exp_addr exp_load, all hex
// op 1 is a store and 0 a load; exp_load is unused for stores and x0
1 2 0 00000010 004 12345678 00 00000014 00000000
0 2 0 00000020 ff4 00000000 01 00000014 12345678
0 0 0 00000080 000 00000000 02 00000080 ffffff80
0 0 1 00000100 f81 00000000 03 00000081 00000081
0 0 0 00000082 000 00000000 04 00000082 ffffff82
0 0 0 00000040 003 00000000 05 00000043 00000043
0 0 1 000000c0 003 00000000 06 000000c3 000000c3
0 1 0 00000090 000 00000000 07 00000090 ffff9190
0 1 1 0000008e 004 00000000 08 00000092 00009392
0 1 0 00000030 002 00000000 09 00000032 00003332
0 1 0 000000a0 002 00000000 0a 000000a2 ffffa3a2
0 2 0 00000044 000 00000000 0b 00000044 47464544
1 0 0 00000060 001 aabbccee 00 00000061 00000000
1 1 0 00000064 002 1234beef 00 00000066 00000000
1 0 0 00000060 003 00000011 00 00000063 00000000
0 2 0 00000060 000 00000000 0c 00000060 1162ee60
0 2 0 00000064 000 00000000 0d 00000064 beef6564
1 1 0 00000068 000 ffff8001 00 00000068 00000000
0 1 0 00000068 000 00000000 0e 00000068 ffff8001
0 0 1 00000062 000 00000000 0f 00000062 00000062
0 2 0 00000068 000 00000000 10 00000068 6b6a8001
0 2 0 00000014 000 00000000 00 00000014 00000000
1 2 0 00000100 ffc cafef00d 00 000000fc 00000000
0 0 0 000000f0 00f 00000000 11 000000ff ffffffca
0 1 1 000000fc 000 00000000 12 000000fc 0000f00d
0 2 0 000000fc 000 00000000 13 000000fc cafef00d
0 0 1 000000fd 000 00000000 14 000000fd 000000f0
1 0 0 00000070 002 000000a5 00 00000072 00000000
0 2 0 00000070 000 00000000 15 00000070 73a57170

//--- rv_lsu.f
hw/rv_lsu_pkg.sv
hw/lsu_phase_if.sv
hw/lsu_store_align.sv
hw/lsu_request.sv
hw/lsu_load_align.sv
hw/rv_lsu.sv
tests/rv_lsu_checker.sv
tests/rv_lsu_tb.sv

//--- Makefile
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= rv_lsu_tb
FILELIST  ?= rv_lsu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= all tests passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, not the simulator's exit status
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/rv_lsu_tb.sv
// Load/store unit testbench
// Drives requests from the stimulus file, models a 64-word AHB-Lite
// slave with random wait states and bounds the run with a cycle limit

`default_nettype none

module rv_lsu_tb;
   import rv_lsu_pkg::*;

   localparam int max_req = 64;
   localparam int stim_cols = 9;
   localparam int mem_words = 64;
   localparam int reset_cycles = 10;
   localparam logic [31:0] no_entry = 32'hffff_ffff;

   logic clk;
   logic rst_n;
   logic req;
   logic req_write;
   mem_size_t req_size;
   logic req_unsigned;
   data_t req_base;
   logic [offset_w-1:0] req_offset;
   data_t req_wdata;
   reg_idx_t req_rd;
   logic req_ready;
   data_t haddr;
   logic [htrans_w-1:0] htrans;
   logic hwrite;
   logic [hsize_w-1:0] hsize;
   data_t hwdata;
   data_t hrdata;
   logic hready;
   logic wb_valid;
   reg_idx_t wb_rd;
   data_t wb_data;

   logic end_of_test;
   int chk_errors;
   int tb_errors;
   int num_req;
   int cycle_cnt;
   int cycle_limit;

   logic [31:0] stim [0:max_req*stim_cols-1];
   data_t mem [0:mem_words-1];

   rv_lsu u_rv_lsu (
      .clk(clk), .rst_n(rst_n), .req(req), .req_write(req_write), .req_size(req_size),
      .req_unsigned(req_unsigned), .req_base(req_base), .req_offset(req_offset),
      .req_wdata(req_wdata), .req_rd(req_rd), .req_ready(req_ready), .haddr(haddr),
      .htrans(htrans), .hwrite(hwrite), .hsize(hsize), .hwdata(hwdata), .hrdata(hrdata),
      .hready(hready), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
   );

   rv_lsu_checker u_checker (
      .clk(clk), .rst_n(rst_n), .req(req), .req_ready(req_ready), .haddr(haddr),
      .htrans(htrans), .hwrite(hwrite), .hsize(hsize), .hready(hready),
      .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
      .end_of_test(end_of_test), .error_count(chk_errors)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Slave side lane write selected by size and low address bits
   task automatic write_mem_lanes(input data_t addr, input logic [hsize_w-1:0] size,
                                  input data_t wdata);
      int w;
      int lane;
      w = int'(addr[7:2]);
      lane = int'(addr[1:0]);
      if (size == 3'd0) begin
         mem[w][8*lane +: 8] = wdata[8*lane +: 8];
      end else if (size == 3'd1 && addr[1]) begin
         mem[w][31:16] = wdata[31:16];
      end else if (size == 3'd1) begin
         mem[w][15:0] = wdata[15:0];
      end else begin
         mem[w] = wdata;
      end
   endtask

   // ====================
   // AHB-Lite slave model
   // ====================

   initial begin : slave_model
      integer seed;
      logic [31:0] rnd;
      logic s_ready, s_acc, s_write;
      logic [hsize_w-1:0] s_size;
      data_t s_addr, s_wdata;
      logic dp_valid, dp_write;
      logic [hsize_w-1:0] dp_size;
      data_t dp_addr;
      int wait_cnt;
      int i;
      seed = 32'h9dd2ebe3;
      hready = 1'b1;
      hrdata = '0;
      dp_valid = 1'b0;
      dp_write = 1'b0;
      dp_size = '0;
      dp_addr = '0;
      wait_cnt = 0;
      // Every byte holds its own byte address
      for (i = 0; i < mem_words; i++) begin
         mem[i] = {8'(4*i+3), 8'(4*i+2), 8'(4*i+1), 8'(4*i)};
      end
      forever begin
         @(negedge clk);
         s_ready = hready;
         s_acc = rst_n && hready && (htrans == htrans_nonseq);
         s_addr = haddr;
         s_write = hwrite;
         s_size = hsize;
         s_wdata = hwdata;
         @(posedge clk);
         #1;
         if (s_ready) begin
            if (dp_valid && dp_write) write_mem_lanes(dp_addr, dp_size, s_wdata);
            dp_valid = s_acc;
            dp_write = s_write;
            dp_size = s_size;
            dp_addr = s_addr;
            rnd = $random(seed);
            wait_cnt = s_acc ? int'(rnd[1:0]) : 0;
         end else begin
            wait_cnt = wait_cnt - 1;
         end
         hready = (wait_cnt == 0);
         hrdata = mem[dp_addr[7:2]];
      end
   end

   // ====================
   // Request driver
   // ====================

   initial begin : driver
      int idx;
      int b;
      logic acc;
      rst_n = 1'b0;
      req = 1'b0;
      req_write = 1'b0;
      req_size = mem_byte;
      req_unsigned = 1'b0;
      req_base = '0;
      req_offset = '0;
      req_wdata = '0;
      req_rd = '0;
      end_of_test = 1'b0;
      tb_errors = 0;
      num_req = 0;
      for (idx = 0; idx < max_req * stim_cols; idx++) begin
         stim[idx] = no_entry;
      end
      $readmemh("tests/rv_lsu_stim.txt", stim);
      while (num_req < max_req && stim[num_req*stim_cols] != no_entry) begin
         num_req++;
      end
      if (num_req == 0) begin
         $display("no requests found in the stimulus file");
         tb_errors++;
      end
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst_n = 1'b1;
      idx = 0;
      // Requests go back to back and each is held until accepted
      while (idx < num_req) begin
         b = idx * stim_cols;
         req = 1'b1;
         req_write = stim[b][0];
         req_size = mem_size_t'(stim[b+1][1:0]);
         req_unsigned = stim[b+2][0];
         req_base = stim[b+3];
         req_offset = stim[b+4][offset_w-1:0];
         req_wdata = stim[b+5];
         req_rd = stim[b+6][reg_idx_w-1:0];
         @(negedge clk);
         acc = req_ready;
         @(posedge clk);
         #1;
         if (acc) idx++;
      end
      req = 1'b0;
      // Last data phase ends on the first ready cycle
      @(negedge clk);
      while (!hready) @(negedge clk);
      @(posedge clk);
      #1;
      end_of_test = 1'b1;
      repeat (2) @(negedge clk);
      $display("summary: %0d errors, %0d requests", chk_errors + tb_errors, num_req);
      if (chk_errors + tb_errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   initial begin : watchdog
      cycle_cnt = 0;
      @(posedge clk);
      cycle_limit = num_req * 6 + 200;
      while (cycle_cnt < cycle_limit) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/rv_lsu_checker.sv
// Load/store unit checker
// Watches the bus and write-back ports of the DUT and compares every
// accepted request and every load result with the stimulus file

`default_nettype none

module rv_lsu_checker (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            req,
   input  logic                            req_ready,
   input  rv_lsu_pkg::data_t               haddr,
   input  logic [rv_lsu_pkg::htrans_w-1:0] htrans,
   input  logic                            hwrite,
   input  logic [rv_lsu_pkg::hsize_w-1:0]  hsize,
   input  logic                            hready,
   input  logic                            wb_valid,
   input  rv_lsu_pkg::reg_idx_t            wb_rd,
   input  rv_lsu_pkg::data_t               wb_data,
   input  logic                            end_of_test,
   output int                              error_count
);
   import rv_lsu_pkg::*;

   localparam int max_req = 64;
   localparam int stim_cols = 9;

   logic [31:0] stim [0:max_req*stim_cols-1];
   // Indices of loads waiting for their data phase in issue order
   int load_q [$];
   int accepted;
   int num_req;
   logic held;
   data_t held_addr;
   logic end_done;

   task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      $display("error t=%0t %s expected %h actual %h", $time, sig, exp_val, act_val);
      error_count++;
   endtask

   initial begin : compare
      int b;
      int idx;
      error_count = 0;
      accepted = 0;
      num_req = 0;
      held = 1'b0;
      held_addr = '0;
      end_done = 1'b0;
      for (idx = 0; idx < max_req * stim_cols; idx++) begin
         stim[idx] = 32'hffff_ffff;
      end
      $readmemh("tests/rv_lsu_stim.txt", stim);
      while (num_req < max_req && stim[num_req*stim_cols] != 32'hffff_ffff) begin
         num_req++;
      end
      forever begin
         @(negedge clk);
         if (rst_n) begin
            if (req_ready !== hready) report_mismatch("req_ready", 32'(hready), 32'(req_ready));
            if (htrans !== (req ? htrans_nonseq : htrans_idle)) begin
               report_mismatch("htrans", 32'(req ? htrans_nonseq : htrans_idle), 32'(htrans));
            end
            // A stalled address phase must stay on the bus unchanged
            if (held && (htrans !== htrans_nonseq || haddr !== held_addr)) begin
               $display("address phase changed during a wait state at t=%0t", $time);
               error_count++;
            end
            // Retire the older load before the new request is counted
            if (wb_valid) begin
               if (load_q.size() == 0) begin
                  $display("write-back to x%0d at t=%0t with no load outstanding", wb_rd, $time);
                  error_count++;
               end else begin
                  idx = load_q.pop_front();
                  b = idx * stim_cols;
                  if (wb_rd !== stim[b+6][4:0]) report_mismatch("wb_rd", stim[b+6], 32'(wb_rd));
                  if (wb_data !== stim[b+8]) report_mismatch("wb_data", stim[b+8], wb_data);
               end
            end
            if (hready && htrans === htrans_nonseq) begin
               if (accepted >= num_req) begin
                  $display("request accepted at t=%0t beyond the end of the stimulus", $time);
                  error_count++;
               end else begin
                  b = accepted * stim_cols;
                  if (haddr !== stim[b+7]) report_mismatch("haddr", stim[b+7], haddr);
                  if (hwrite !== stim[b][0]) report_mismatch("hwrite", stim[b], 32'(hwrite));
                  if (hsize !== stim[b+1][2:0]) report_mismatch("hsize", stim[b+1], 32'(hsize));
                  // Loads to x0 never come back
                  if (stim[b][0] == 1'b0 && stim[b+6][4:0] != 5'd0) load_q.push_back(accepted);
               end
               accepted++;
            end
            held = (htrans === htrans_nonseq) && !hready;
            held_addr = haddr;
         end
         if (end_of_test && !end_done) begin
            end_done = 1'b1;
            if (load_q.size() != 0) begin
               $display("%0d loads were accepted but never returned a result", load_q.size());
               error_count++;
            end
            if (accepted != num_req) begin
               $display("only %0d of %0d requests were accepted", accepted, num_req);
               error_count++;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/rv_lsu.sv
// Top level of the RV32 load/store unit
// Connects the request stage, which drives the AHB-Lite address
// phase and store data, to the load stage, which returns loaded
// values to the register file

`default_nettype none

module rv_lsu (
   input  logic                              clk,
   input  logic                              rst_n,
   // Request side
   input  logic                              req,
   input  logic                              req_write,
   input  rv_lsu_pkg::mem_size_t             req_size,
   input  logic                              req_unsigned,
   input  rv_lsu_pkg::data_t                 req_base,
   input  logic [rv_lsu_pkg::offset_w-1:0]   req_offset,
   input  rv_lsu_pkg::data_t                 req_wdata,
   input  rv_lsu_pkg::reg_idx_t              req_rd,
   output logic                              req_ready,
   // AHB-Lite data port
   output rv_lsu_pkg::data_t                 haddr,
   output logic [rv_lsu_pkg::htrans_w-1:0]   htrans,
   output logic                              hwrite,
   output logic [rv_lsu_pkg::hsize_w-1:0]    hsize,
   output rv_lsu_pkg::data_t                 hwdata,
   input  rv_lsu_pkg::data_t                 hrdata,
   input  logic                              hready,
   // Register file write-back
   output logic                              wb_valid,
   output rv_lsu_pkg::reg_idx_t              wb_rd,
   output rv_lsu_pkg::data_t                 wb_data
);

   lsu_phase_if u_phase ();

   // A new request goes out whenever the bus can take an address phase
   assign req_ready = hready;

   lsu_request u_request (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (req),
      .req_write    (req_write),
      .req_size     (req_size),
      .req_unsigned (req_unsigned),
      .req_base     (req_base),
      .req_offset   (req_offset),
      .req_wdata    (req_wdata),
      .req_rd       (req_rd),
      .hready       (hready),
      .haddr        (haddr),
      .htrans       (htrans),
      .hwrite       (hwrite),
      .hsize        (hsize),
      .hwdata       (hwdata),
      .phase        (u_phase.producer)
   );

   lsu_load_align u_load_align (
      .phase    (u_phase.consumer),
      .hrdata   (hrdata),
      .hready   (hready),
      .wb_valid (wb_valid),
      .wb_rd    (wb_rd),
      .wb_data  (wb_data)
   );

endmodule

`default_nettype wire

//--- hw/lsu_load_align.sv
// Load lane extraction
// Picks the addressed byte or halfword out of hrdata during the
// data phase, sign- or zero-extends it and raises the write-back
// strobe when the load completes

`default_nettype none

module lsu_load_align (
   lsu_phase_if.consumer         phase,
   input  rv_lsu_pkg::data_t     hrdata,
   input  logic                  hready,
   output logic                  wb_valid,
   output rv_lsu_pkg::reg_idx_t  wb_rd,
   output rv_lsu_pkg::data_t     wb_data
);
   import rv_lsu_pkg::*;

   logic [7:0] byte_lane;
   logic [15:0] half_lane;
   logic fill;

   // Lane selection from the registered low address bits
   assign byte_lane = hrdata[8*phase.addr_lo +: 8];
   assign half_lane = phase.addr_lo[1] ? hrdata[31:16] : hrdata[15:0];

   always_comb begin
      case (phase.size)
         mem_byte: begin
            fill = byte_lane[7] & ~phase.is_unsigned;
            wb_data = {{(data_w - 8){fill}}, byte_lane};
         end
         mem_half: begin
            fill = half_lane[15] & ~phase.is_unsigned;
            wb_data = {{(data_w - 16){fill}}, half_lane};
         end
         default: begin
            // Full word passes through
            fill = 1'b0;
            wb_data = hrdata;
         end
      endcase
   end

   // Loads to x0 are dropped since x0 is hardwired to zero
   assign wb_valid = phase.valid & ~phase.write & hready & (phase.rd != '0);
   assign wb_rd = phase.rd;

endmodule

`default_nettype wire

//--- hw/lsu_request.sv
// Load/store request stage
// Forms the effective address, drives the AHB address phase and
// registers the data-phase record and the lane-aligned store word
// whenever the bus is ready, so address and data phases overlap

`default_nettype none

module lsu_request (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              req,
   input  logic                              req_write,
   input  rv_lsu_pkg::mem_size_t             req_size,
   input  logic                              req_unsigned,
   input  rv_lsu_pkg::data_t                 req_base,
   input  logic [rv_lsu_pkg::offset_w-1:0]   req_offset,
   input  rv_lsu_pkg::data_t                 req_wdata,
   input  rv_lsu_pkg::reg_idx_t              req_rd,
   input  logic                              hready,
   output rv_lsu_pkg::data_t                 haddr,
   output logic [rv_lsu_pkg::htrans_w-1:0]   htrans,
   output logic                              hwrite,
   output logic [rv_lsu_pkg::hsize_w-1:0]    hsize,
   output rv_lsu_pkg::data_t                 hwdata,
   lsu_phase_if.producer                     phase
);
   import rv_lsu_pkg::*;

   data_t offset_sext;
   data_t lane_data;

   // ====================
   // Address phase
   // ====================

   // Base plus sign-extended 12-bit immediate
   assign offset_sext = {{(data_w - offset_w){req_offset[offset_w-1]}}, req_offset};
   assign haddr = req_base + offset_sext;

   assign htrans = req ? htrans_nonseq : htrans_idle;
   assign hwrite = req_write;
   // Size codes already match hsize
   assign hsize = hsize_w'(req_size);

   // Store data placed on its byte lanes before registering
   lsu_store_align u_store_align (
      .size      (req_size),
      .addr_lo   (haddr[1:0]),
      .wdata     (req_wdata),
      .lane_data (lane_data)
   );

   // ====================
   // Data-phase registers
   // ====================

   // Valid follows req on every ready cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase.valid <= 1'b0;
         hwdata <= '0;
      end else if (hready) begin
         phase.valid <= req;
         hwdata <= lane_data;
      end
   end

   // Attributes of the transfer entering its data phase
   always_ff @(posedge clk) begin
      if (hready) begin
         phase.write <= req_write;
         phase.size <= req_size;
         phase.is_unsigned <= req_unsigned;
         phase.addr_lo <= haddr[1:0];
         phase.rd <= req_rd;
      end
   end

endmodule

`default_nettype wire

//--- hw/lsu_store_align.sv
// Store lane placement
// Moves a byte or halfword of store data onto the byte lanes
// selected by the low address bits; lanes not written are zero

`default_nettype none

module lsu_store_align (
   input  rv_lsu_pkg::mem_size_t size,
   input  logic [1:0]            addr_lo,
   input  rv_lsu_pkg::data_t     wdata,
   output rv_lsu_pkg::data_t     lane_data
);
   import rv_lsu_pkg::*;

   always_comb begin
      case (size)
         mem_byte: begin
            case (addr_lo)
               2'b00: lane_data = {24'b0, wdata[7:0]};
               2'b01: lane_data = {16'b0, wdata[7:0], 8'b0};
               2'b10: lane_data = {8'b0, wdata[7:0], 16'b0};
               default: lane_data = {wdata[7:0], 24'b0};
            endcase
         end
         mem_half: begin
            // Only bit 1 selects the halfword
            if (addr_lo[1]) begin
               lane_data = {wdata[15:0], 16'b0};
            end else begin
               lane_data = {16'b0, wdata[15:0]};
            end
         end
         mem_word: begin
            lane_data = wdata;
         end
         default: begin
            lane_data = wdata;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- hw/lsu_phase_if.sv
// Data-phase record of the load/store unit
// Captured at the end of the address phase and held for the
// duration of the data phase, so the load stage knows how to
// interpret hrdata and where the result goes

`default_nettype none

interface lsu_phase_if;
   import rv_lsu_pkg::*;

   // A transfer is in its data phase
   logic valid;
   logic write;
   mem_size_t size;
   logic is_unsigned;
   // Low address bits select the byte lane
   logic [1:0] addr_lo;
   reg_idx_t rd;

   modport producer (
      output valid,
      output write,
      output size,
      output is_unsigned,
      output addr_lo,
      output rd
   );

   modport consumer (
      input valid,
      input write,
      input size,
      input is_unsigned,
      input addr_lo,
      input rd
   );

endinterface

`default_nettype wire

//--- hw/rv_lsu_pkg.sv
// Load/store unit package
// Data and address widths, register index width, access size codes
// and the AHB-Lite transfer codes used by the data port

`default_nettype none

package rv_lsu_pkg;

   // ====================
   // Widths
   // ====================

   // Data bus and address width
   localparam int data_w = 32;

   // Destination register index
   localparam int reg_idx_w = 5;

   // Signed immediate offset carried with each request
   localparam int offset_w = 12;

   // AHB control field widths
   localparam int htrans_w = 2;
   localparam int hsize_w = 3;

   // ====================
   // Types
   // ====================

   typedef logic [data_w-1:0] data_t;
   typedef logic [reg_idx_w-1:0] reg_idx_t;

   // Access size encoded as the AHB hsize code so it
   // can be driven onto the bus without translation
   typedef enum logic [1:0] {
      mem_byte = 2'd0,
      mem_half = 2'd1,
      mem_word = 2'd2
   } mem_size_t;

   // ====================
   // Bus encodings
   // ====================

   // Only single transfers without bursts
   localparam logic [htrans_w-1:0] htrans_idle = 2'b00;
   localparam logic [htrans_w-1:0] htrans_nonseq = 2'b10;

endpackage

`default_nettype wire
